/* rps_game.f */
+incdir+include
hdl/rps_pkg.sv
hdl/spin_counter.sv
hdl/icon_sweep.sv
hdl/round_judge.sv
hdl/rps_game_fsm.sv
hdl/rps_game_top.sv
verification/clock_gen.sv
verification/rps_game_tb.sv

/* verification/rps_game_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rps_defs.svh"

module rps_game_tb;
	import rps_pkg::*;

	localparam int ROUNDS = 60;
	localparam int ROUND_BOUND = 400;
	localparam int CYCLE_LIMIT = ROUNDS * ROUND_BOUND + 4;
	localparam int T_RESET = 0;
	localparam int T_SPIN = 1;
	localparam int T_SCORE = 2;
	localparam int T_PIXEL = 3;
	localparam int T_OUTCOME = 4;
	localparam int T_STREAK = 5;
	localparam int NUM_TESTS = 6;

	logic clk;
	logic reset;
	logic stop_left;
	logic stop_right;
	logic confirm;
	logic stop_user;
	move_t user_move;
	logic [`SPIN_W-1:0] left_value;
	logic [`SPIN_W-1:0] right_value;
	logic [`SPIN_W-1:0] score;
	logic plot;
	logic [`PIX_X_W-1:0] pix_x;
	logic [`PIX_Y_W-1:0] pix_y;
	logic [`COLOR_W-1:0] color;
	move_t opponent;
	outcome_t outcome;
	logic outcome_valid;
	logic [1:0] streak;
	logic three_wins;

	// reference model state
	game_state_t m_state;
	game_state_t last_state;
	int m_left;
	int m_right;
	int m_score;
	int m_count;
	move_t m_candidate;
	move_t m_player;
	move_t m_opponent;
	outcome_t m_outcome;
	logic m_valid;
	int m_streak;

	integer seed;
	int wait_cnt;
	int sweep_wait;
	int right_spins;
	int cycles;
	int rounds;
	int ties;
	int squares;
	int checks [NUM_TESTS];
	int errors [NUM_TESTS];
	string test_name [NUM_TESTS];

	clock_gen clocks (
		.clk(clk),
		.reset(reset)
	);

	rps_game_top DUT (
		.clk(clk), .reset(reset),
		.stop_left(stop_left), .stop_right(stop_right),
		.confirm(confirm), .stop_user(stop_user), .user_move(user_move),
		.left_value(left_value), .right_value(right_value), .score(score),
		.plot(plot), .pix_x(pix_x), .pix_y(pix_y), .color(color),
		.opponent(opponent), .outcome(outcome), .outcome_valid(outcome_valid),
		.streak(streak), .three_wins(three_wins)
	);

	function automatic int rand_upto(input int max_val);
		logic [31:0] r;
		r = $random(seed);
		return r % (max_val + 1);
	endfunction

	function automatic int wrap_spin(input int v);
		return (v == `SPIN_MAX) ? 0 : v + 1;
	endfunction

	// the move that m beats
	function automatic move_t prey_of(input move_t m);
		case (m)
			MOVE_ROCK: return MOVE_SCISSORS;
			MOVE_SCISSORS: return MOVE_PAPER;
			default: return MOVE_ROCK;
		endcase
	endfunction

	function automatic outcome_t decide_winner(input move_t player, input move_t computer);
		if (player == computer)
			return OUT_DRAW;
		else if (prey_of(player) == computer)
			return OUT_PLAYER;
		else
			return OUT_COMPUTER;
	endfunction

	function automatic int corner_x(input move_t m);
		case (m)
			MOVE_ROCK: return `ICON_ROCK_X;
			MOVE_SCISSORS: return `ICON_SCISSORS_X;
			default: return `ICON_PAPER_X;
		endcase
	endfunction

	function automatic int corner_y(input move_t m);
		case (m)
			MOVE_ROCK: return `ICON_ROCK_Y;
			MOVE_SCISSORS: return `ICON_SCISSORS_Y;
			default: return `ICON_PAPER_Y;
		endcase
	endfunction

	task automatic compare_value(input int test_id, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks[test_id]++;
		if (expected !== actual) begin
			errors[test_id]++;
			$display("Fail %s: %s expected %0d actual %0d (cycle %0d)",
				test_name[test_id], what, expected, actual, cycles);
		end
	endtask

	// one rising edge of the model on the inputs the DUT just sampled
	task automatic step_model;
		outcome_t res;
		if (reset) begin
			m_state = SPIN_LEFT;
			m_left = 0;
			m_right = 0;
			m_score = 0;
			m_count = 0;
			m_candidate = MOVE_SCISSORS;
			m_opponent = MOVE_SCISSORS;
			m_outcome = OUT_NONE;
			m_valid = 1'b0;
			m_streak = 0;
		end else begin
			m_valid = (m_state == COMPARE);
			case (m_state)
				SPIN_LEFT: begin
					if (stop_left)
						m_state = SPIN_RIGHT;
					else
						m_left = wrap_spin(m_left);
				end
				SPIN_RIGHT: begin
					if (stop_right) begin
						m_score = m_left - m_right;
						if (m_score < 0)
							m_score = -m_score;
						if (m_left == m_right) begin
							m_state = SPIN_LEFT;
							ties++;
						end else begin
							m_state = GET_USER;
						end
					end else begin
						m_right = wrap_spin(m_right);
					end
				end
				GET_USER: begin
					if (confirm) begin
						m_player = user_move;
						m_state = DRAW_ICON;
					end
				end
				DRAW_ICON: begin
					if (m_count == 15)
						m_state = CLEAR_ICON;
					m_count = (m_count + 1) % 16;
				end
				CLEAR_ICON: begin
					if (m_count == 15) begin
						squares++;
						if (stop_user) begin
							m_opponent = m_candidate;
							m_state = COMPARE;
						end else begin
							m_candidate = (m_candidate == MOVE_SCISSORS) ? MOVE_ROCK :
								(m_candidate == MOVE_ROCK) ? MOVE_PAPER : MOVE_SCISSORS;
							m_state = DRAW_ICON;
						end
					end
					m_count = (m_count + 1) % 16;
				end
				default: begin
					res = decide_winner(m_player, m_opponent);
					m_outcome = res;
					if (res == OUT_PLAYER && m_streak < 3)
						m_streak++;
					else if (res == OUT_COMPUTER)
						m_streak = 0;
					m_state = (res == OUT_COMPUTER) ? SPIN_LEFT : GET_USER;
					rounds++;
				end
			endcase
		end
	endtask

	// inputs for the next edge from the state the DUT is now in
	task automatic drive_inputs;
		if (m_state != last_state) begin
			wait_cnt = rand_upto(40);
			if (m_state == DRAW_ICON && last_state == GET_USER)
				sweep_wait = rand_upto(96);
			// every fourth right spin stops level with the left value
			if (m_state == SPIN_RIGHT) begin
				right_spins++;
				if (right_spins % 4 == 0)
					wait_cnt = (m_left - m_right + `SPIN_MAX + 1) % (`SPIN_MAX + 1);
			end
		end
		last_state = m_state;
		stop_left <= 1'b0;
		stop_right <= 1'b0;
		confirm <= 1'b0;
		user_move <= move_t'(rand_upto(2));
		case (m_state)
			SPIN_LEFT, SPIN_RIGHT, GET_USER: begin
				stop_user <= 1'b0;
				if (wait_cnt == 0) begin
					stop_left <= (m_state == SPIN_LEFT);
					stop_right <= (m_state == SPIN_RIGHT);
					confirm <= (m_state == GET_USER);
				end else begin
					wait_cnt--;
				end
			end
			DRAW_ICON, CLEAR_ICON: begin
				// stays high once set until the compare
				if (sweep_wait == 0)
					stop_user <= 1'b1;
				else
					sweep_wait--;
			end
			default: stop_user <= 1'b0;
		endcase
	endtask

	task automatic check_outputs;
		logic exp_plot;
		exp_plot = (m_state == DRAW_ICON || m_state == CLEAR_ICON);
		compare_value(T_SPIN, "left_value", m_left, left_value);
		compare_value(T_SPIN, "right_value", m_right, right_value);
		compare_value(T_SCORE, "score", m_score, score);
		compare_value(T_PIXEL, "plot", exp_plot, plot);
		if (exp_plot) begin
			compare_value(T_PIXEL, "pix_x", corner_x(m_candidate) + m_count % 4, pix_x);
			compare_value(T_PIXEL, "pix_y", corner_y(m_candidate) + m_count / 4, pix_y);
			compare_value(T_PIXEL, "color",
				(m_state == CLEAR_ICON) ? `COLOR_ERASE : `COLOR_DRAW, color);
		end
		compare_value(T_OUTCOME, "opponent", m_opponent, opponent);
		compare_value(T_OUTCOME, "outcome", m_outcome, outcome);
		compare_value(T_OUTCOME, "outcome_valid", m_valid, outcome_valid);
		compare_value(T_STREAK, "streak", m_streak, streak);
		compare_value(T_STREAK, "three_wins", m_streak == 3, three_wins);
	endtask

	task automatic check_reset_values;
		compare_value(T_RESET, "left_value", 0, left_value);
		compare_value(T_RESET, "right_value", 0, right_value);
		compare_value(T_RESET, "score", 0, score);
		compare_value(T_RESET, "plot", 0, plot);
		compare_value(T_RESET, "opponent", MOVE_SCISSORS, opponent);
		compare_value(T_RESET, "outcome", OUT_NONE, outcome);
		compare_value(T_RESET, "outcome_valid", 0, outcome_valid);
		compare_value(T_RESET, "streak", 0, streak);
		compare_value(T_RESET, "three_wins", 0, three_wins);
	endtask

	task automatic report_test(input int test_id);
		if (errors[test_id] == 0)
			$display("%s: ok, %0d checks", test_name[test_id], checks[test_id]);
		else
			$display("%s: %0d errors in %0d checks", test_name[test_id],
				errors[test_id], checks[test_id]);
	endtask

	initial begin
		int total_checks;
		int total_errors;
		int failed_tests;
		int tail;
		logic reset_done;
		logic timed_out;
		seed = 32'h85c541dd;
		stop_left = 1'b0;
		stop_right = 1'b0;
		confirm = 1'b0;
		stop_user = 1'b0;
		user_move = MOVE_SCISSORS;
		test_name = '{"reset", "spinning", "score_tie", "pixel_stream", "outcome", "streak"};
		for (int i = 0; i < NUM_TESTS; i++) begin
			checks[i] = 0;
			errors[i] = 0;
		end
		m_player = MOVE_SCISSORS;
		last_state = COMPARE;
		wait_cnt = 0;
		sweep_wait = 0;
		right_spins = 0;
		cycles = 0;
		rounds = 0;
		ties = 0;
		squares = 0;
		tail = 0;
		reset_done = 1'b0;
		timed_out = 1'b0;
		while ((rounds < ROUNDS || tail < 2) && !timed_out) begin
			@(posedge clk);
			step_model();
			drive_inputs();
			@(negedge clk);
			cycles++;
			if (!reset && !reset_done) begin
				check_reset_values();
				report_test(T_RESET);
				reset_done = 1'b1;
			end
			if (!reset)
				check_outputs();
			if (rounds >= ROUNDS)
				tail++;
			if (cycles >= CYCLE_LIMIT)
				timed_out = 1'b1;
		end
		if (timed_out)
			$display("timeout: only %0d of %0d rounds finished in %0d cycles",
				rounds, ROUNDS, cycles);
		for (int i = 1; i < NUM_TESTS; i++)
			report_test(i);
		total_checks = 0;
		total_errors = 0;
		failed_tests = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			total_checks += checks[i];
			total_errors += errors[i];
			if (errors[i] != 0)
				failed_tests++;
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d ties, %0d squares",
			NUM_TESTS, failed_tests, total_checks, total_errors, ties, squares);
		if (!timed_out && reset_done && total_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for the first four rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* hdl/rps_game_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rps_defs.svh"

module rps_game_top (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  stop_left,
	input  wire                  stop_right,
	input  wire                  confirm,
	input  wire                  stop_user,
	input  rps_pkg::move_t       user_move,
	output logic [`SPIN_W-1:0]  left_value,
	output logic [`SPIN_W-1:0]  right_value,
	output logic [`SPIN_W-1:0]  score,
	output logic                 plot,
	output logic [`PIX_X_W-1:0] pix_x,
	output logic [`PIX_Y_W-1:0] pix_y,
	output logic [`COLOR_W-1:0] color,
	output rps_pkg::move_t       opponent,
	output rps_pkg::outcome_t    outcome,
	output logic                 outcome_valid,
	output logic [1:0]           streak,
	output logic                 three_wins
);
	import rps_pkg::*;

	logic spin_left_en;
	logic spin_right_en;
	logic score_load;
	logic user_load;
	logic sweep_en;
	logic sweep_erase;
	logic opponent_load;
	logic judge_en;
	logic spin_tie;
	logic sweep_done;
	move_t candidate;
	outcome_t round_outcome;

	rps_game_fsm fsm (
		.clk(clk),
		.reset(reset),
		.stop_left(stop_left),
		.stop_right(stop_right),
		.confirm(confirm),
		.stop_user(stop_user),
		.spin_tie(spin_tie),
		.sweep_done(sweep_done),
		.round_outcome(round_outcome),
		.spin_left_en(spin_left_en),
		.spin_right_en(spin_right_en),
		.score_load(score_load),
		.user_load(user_load),
		.sweep_en(sweep_en),
		.sweep_erase(sweep_erase),
		.candidate(candidate),
		.opponent_load(opponent_load),
		.judge_en(judge_en)
	);

	spin_counter left_spin (
		.clk(clk),
		.reset(reset),
		.advance(spin_left_en),
		.value(left_value)
	);

	spin_counter right_spin (
		.clk(clk),
		.reset(reset),
		.advance(spin_right_en),
		.value(right_value)
	);

	icon_sweep sweep (
		.clk(clk),
		.reset(reset),
		.sweep_en(sweep_en),
		.sweep_erase(sweep_erase),
		.candidate(candidate),
		.sweep_done(sweep_done),
		.plot(plot),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.color(color)
	);

	round_judge judge (
		.clk(clk),
		.reset(reset),
		.left_value(left_value),
		.right_value(right_value),
		.score_load(score_load),
		.user_load(user_load),
		.user_move(user_move),
		.opponent_load(opponent_load),
		.candidate(candidate),
		.judge_en(judge_en),
		.spin_tie(spin_tie),
		.score(score),
		.opponent(opponent),
		.round_outcome(round_outcome),
		.outcome(outcome),
		.outcome_valid(outcome_valid),
		.streak(streak),
		.three_wins(three_wins)
	);

endmodule

`default_nettype wire

/* hdl/rps_game_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module rps_game_fsm (
	input  wire                clk,
	input  wire                reset,
	input  wire                stop_left,
	input  wire                stop_right,
	input  wire                confirm,
	input  wire                stop_user,
	input  wire                spin_tie,
	input  wire                sweep_done,
	input  rps_pkg::outcome_t  round_outcome,
	output logic               spin_left_en,
	output logic               spin_right_en,
	output logic               score_load,
	output logic               user_load,
	output logic               sweep_en,
	output logic               sweep_erase,
	output rps_pkg::move_t     candidate,
	output logic               opponent_load,
	output logic               judge_en
);
	import rps_pkg::*;

	game_state_t state;
	game_state_t next_state;
	logic rotate;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SPIN_LEFT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			SPIN_LEFT: begin
				if (stop_left) begin
					next_state = SPIN_RIGHT;
				end
			end
			SPIN_RIGHT: begin
				// a tie throws the round back to spinning
				if (stop_right) begin
					next_state = spin_tie ? SPIN_LEFT : GET_USER;
				end
			end
			GET_USER: begin
				if (confirm) begin
					next_state = DRAW_ICON;
				end
			end
			DRAW_ICON: begin
				if (sweep_done) begin
					next_state = CLEAR_ICON;
				end
			end
			CLEAR_ICON: begin
				if (sweep_done) begin
					next_state = stop_user ? COMPARE : DRAW_ICON;
				end
			end
			COMPARE: begin
				next_state = (round_outcome == OUT_COMPUTER) ? SPIN_LEFT : GET_USER;
			end
			default: begin
				next_state = SPIN_LEFT;
			end
		endcase
	end

	always_comb begin
		spin_left_en = 1'b0;
		spin_right_en = 1'b0;
		score_load = 1'b0;
		user_load = 1'b0;
		sweep_en = 1'b0;
		sweep_erase = 1'b0;
		opponent_load = 1'b0;
		judge_en = 1'b0;
		case (state)
			SPIN_LEFT: begin
				spin_left_en = !stop_left;
			end
			SPIN_RIGHT: begin
				spin_right_en = !stop_right;
				score_load = stop_right;
			end
			GET_USER: begin
				user_load = confirm;
			end
			DRAW_ICON: begin
				sweep_en = 1'b1;
			end
			CLEAR_ICON: begin
				sweep_en = 1'b1;
				sweep_erase = 1'b1;
				opponent_load = sweep_done && stop_user;
			end
			COMPARE: begin
				judge_en = 1'b1;
			end
			default: begin
				judge_en = 1'b0;
			end
		endcase
	end

	// next icon only after a full erase without stop_user
	assign rotate = (state == CLEAR_ICON) && sweep_done && !stop_user;

	always_ff @(posedge clk) begin
		if (reset) begin
			candidate <= MOVE_SCISSORS;
		end else if (rotate) begin
			case (candidate)
				MOVE_SCISSORS: candidate <= MOVE_ROCK;
				MOVE_ROCK: candidate <= MOVE_PAPER;
				default: candidate <= MOVE_SCISSORS;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/round_judge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rps_defs.svh"

module round_judge (
	input  wire                  clk,
	input  wire                  reset,
	input  wire [`SPIN_W-1:0]   left_value,
	input  wire [`SPIN_W-1:0]   right_value,
	input  wire                  score_load,
	input  wire                  user_load,
	input  rps_pkg::move_t       user_move,
	input  wire                  opponent_load,
	input  rps_pkg::move_t       candidate,
	input  wire                  judge_en,
	output logic                 spin_tie,
	output logic [`SPIN_W-1:0]  score,
	output rps_pkg::move_t       opponent,
	output rps_pkg::outcome_t    round_outcome,
	output rps_pkg::outcome_t    outcome,
	output logic                 outcome_valid,
	output logic [1:0]           streak,
	output logic                 three_wins
);
	import rps_pkg::*;

	move_t player_move;
	move_t p;
	move_t o;

	assign spin_tie = (left_value == right_value);

	always_ff @(posedge clk) begin
		if (reset) begin
			score <= '0;
			player_move <= MOVE_SCISSORS;
			opponent <= MOVE_SCISSORS;
		end else begin
			// abs difference, zero on a tie
			if (score_load) begin
				score <= (left_value > right_value) ? left_value - right_value
					: right_value - left_value;
			end
			if (user_load) begin
				player_move <= user_move;
			end
			if (opponent_load) begin
				opponent <= candidate;
			end
		end
	end

	// unused code 3 counts as paper
	assign p = (player_move == MOVE_SCISSORS || player_move == MOVE_ROCK) ?
		player_move : MOVE_PAPER;
	assign o = (opponent == MOVE_SCISSORS || opponent == MOVE_ROCK) ? opponent : MOVE_PAPER;

	always_comb begin
		if (p == o) begin
			round_outcome = OUT_DRAW;
		end else if ((p == MOVE_ROCK && o == MOVE_SCISSORS) ||
				(p == MOVE_SCISSORS && o == MOVE_PAPER) ||
				(p == MOVE_PAPER && o == MOVE_ROCK)) begin
			round_outcome = OUT_PLAYER;
		end else begin
			round_outcome = OUT_COMPUTER;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outcome <= OUT_NONE;
			outcome_valid <= 1'b0;
			streak <= 2'd0;
		end else begin
			outcome_valid <= judge_en;
			if (judge_en) begin
				outcome <= round_outcome;
				// saturates at three, draws leave it alone
				if (round_outcome == OUT_PLAYER && streak != 2'd3) begin
					streak <= streak + 1'b1;
				end else if (round_outcome == OUT_COMPUTER) begin
					streak <= 2'd0;
				end
			end
		end
	end

	assign three_wins = (streak == 2'd3);

endmodule

`default_nettype wire

/* hdl/icon_sweep.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rps_defs.svh"

module icon_sweep (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   sweep_en,
	input  wire                   sweep_erase,
	input  rps_pkg::move_t        candidate,
	output logic                  sweep_done,
	output logic                  plot,
	output logic [`PIX_X_W-1:0]  pix_x,
	output logic [`PIX_Y_W-1:0]  pix_y,
	output logic [`COLOR_W-1:0]  color
);
	import rps_pkg::*;

	logic [`SQUARE_CNT_W-1:0] count;
	logic [`PIX_X_W-1:0] corner_x;
	logic [`PIX_Y_W-1:0] corner_y;

	// wraps from 15 to 0 on its own, ready for the next square
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (sweep_en) begin
			count <= count + 1'b1;
		end
	end

	always_comb begin
		case (candidate)
			MOVE_SCISSORS: begin
				corner_x = `ICON_SCISSORS_X;
				corner_y = `ICON_SCISSORS_Y;
			end
			MOVE_ROCK: begin
				corner_x = `ICON_ROCK_X;
				corner_y = `ICON_ROCK_Y;
			end
			default: begin
				corner_x = `ICON_PAPER_X;
				corner_y = `ICON_PAPER_Y;
			end
		endcase
	end

	// low count bits step across, high bits step down
	assign pix_x = corner_x + {{(`PIX_X_W-2){1'b0}}, count[1:0]};
	assign pix_y = corner_y + {{(`PIX_Y_W-2){1'b0}}, count[3:2]};
	assign color = sweep_erase ? `COLOR_ERASE : `COLOR_DRAW;
	assign plot = sweep_en;
	assign sweep_done = sweep_en && (count == {`SQUARE_CNT_W{1'b1}});

endmodule

`default_nettype wire

/* hdl/spin_counter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rps_defs.svh"

module spin_counter (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 advance,
	output logic [`SPIN_W-1:0] value
);

	// value holds whenever advance is low, so a stopped
	// counter keeps its result for the judge
	always_ff @(posedge clk) begin
		if (reset) begin
			value <= '0;
		end else if (advance) begin
			if (value == `SPIN_MAX) begin
				value <= '0;
			end else begin
				value <= value + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/rps_pkg.sv */
`default_nettype none

package rps_pkg;

	// code 3 is never driven
	typedef enum logic [1:0] {
		MOVE_SCISSORS = 2'd0,
		MOVE_ROCK     = 2'd1,
		MOVE_PAPER    = 2'd2
	} move_t;

	typedef enum logic [1:0] {
		OUT_PLAYER   = 2'd0,
		OUT_COMPUTER = 2'd1,
		OUT_NONE     = 2'd2,
		OUT_DRAW     = 2'd3
	} outcome_t;

	typedef enum logic [2:0] {
		SPIN_LEFT  = 3'd0,
		SPIN_RIGHT = 3'd1,
		GET_USER   = 3'd2,
		DRAW_ICON  = 3'd3,
		CLEAR_ICON = 3'd4,
		COMPARE    = 3'd5
	} game_state_t;

endpackage

`default_nettype wire

/* include/rps_defs.svh */
`ifndef RPS_DEFS_SVH
`define RPS_DEFS_SVH

// spin counters run 0 to SPIN_MAX and wrap
`define SPIN_MAX 5'd20
`define SPIN_W 5

// 160x120 screen addressing
`define PIX_X_W 8
`define PIX_Y_W 7
`define COLOR_W 3

// 4x4 square, two count bits per axis
`define SQUARE_CNT_W 4

// upper-left corners of the three icons
`define ICON_ROCK_X 8'd20
`define ICON_ROCK_Y 7'd20
`define ICON_SCISSORS_X 8'd40
`define ICON_SCISSORS_Y 7'd40
`define ICON_PAPER_X 8'd60
`define ICON_PAPER_Y 7'd60

`define COLOR_DRAW 3'b100
`define COLOR_ERASE 3'b000

`endif
